/* hw/snd_settings.svh */
/* build-time sizes of the sound board
   ram depth must stay within the 4 KiB D window (aw <= 12) */
`ifndef SND_SETTINGS_SVH
`define SND_SETTINGS_SVH

// work ram address width, 11 gives 2 KiB
// mirrored twice across D000-DFFF
`define SND_RAM_AW 11

// phase accumulator width of the tone channel
// freq register is split into low and high byte
// so keep this between 9 and 16
`define SND_PHASE_W 16

// volume to output magnitude, 8 bit volume << 7
// tops out at 32640 which still fits a signed sample
`define SND_VOL_SHIFT 7

`endif

/* hw/snd_bus_pkg.sv */
/* sound cpu bus types, plain level bus without handshake
   requests are only valid while mreq is high */
package snd_bus_pkg;

    typedef logic [15:0] cpu_addr_t; // z80 style 64 KiB space
    typedef logic [7:0]  cpu_data_t;

    // one bus request as driven by the cpu side
    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t wdata;  // only looked at on writes
        logic      mreq;   // memory request level
        logic      wr;     // high for write, low for read
    } cpu_bus_t;

    // device selects out of the decoder
    // at most one bit high at a time
    typedef struct packed {
        logic rom;     // fixed or banked window
        logic ram;     // work ram, D page
        logic tone;    // tone register pair
        logic bank;    // rom bank bit
        logic latch0;  // main cpu command latch 0
        logic latch1;  // main cpu command latch 1
    } dev_sel_t;

endpackage

/* hw/snd_audio_pkg.sv */
/* audio side types for the tone generator
   phase width comes from the settings header */
`include "snd_settings.svh"

package snd_audio_pkg;

    typedef logic signed [15:0]           sample_t; // two's complement output
    typedef logic [`SND_PHASE_W-1:0]      phase_t;  // accumulator and step
    typedef logic [7:0]                   vol_t;

    // cpu visible register file of the tone channel
    typedef struct packed {
        phase_t     freq;          // phase step per cen_fm
        vol_t       vol_l;
        vol_t       vol_r;
        logic [7:0] timer_period;  // samples per timer tick, 0 stops it
        logic       irq_en;
    } tone_regs_t;

endpackage

/* hw/snd_map.sv */
/* memory map, bank register and read path of the sound cpu
   reads are registered, rom reads stall through wait_n until rom_ok
   adpcm slots at F002/F006 are not decoded and read back FF */
`timescale 1ns/100ps

module snd_map import snd_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_bus_t  cpu,
    input  cpu_data_t snd_latch0,
    input  cpu_data_t snd_latch1,
    input  cpu_data_t rom_data,
    input  logic      rom_ok,
    input  cpu_data_t ram_q,
    input  cpu_data_t tone_q,
    output dev_sel_t  sel,
    output cpu_addr_t rom_addr,
    output logic      rom_cs,
    output cpu_data_t rdata,
    output logic      wait_n
);

    logic      bank;     // upper half of the banked window
    logic      rd_ram;   // last sampled read hit ram
    cpu_data_t rd_mux;   // read data of all non-ram sources
    cpu_data_t rdata_r;

    // address decode
    always_comb begin
        sel      = '0;
        rom_addr = '0;
        if (cpu.mreq) begin
            casez (cpu.addr[15:12])
                4'b0???: begin // 0000-7FFF fixed
                    sel.rom  = 1'b1;
                    rom_addr = {1'b0, cpu.addr[14:0]};
                end
                4'b10??: begin // 8000-BFFF banked
                    sel.rom  = 1'b1;
                    rom_addr = {1'b1, bank, cpu.addr[13:0]};
                end
                4'b1101: sel.ram = 1'b1; // D page, ram mirrors
                4'b1111: begin
                    case (cpu.addr[3:1])
                        3'd0:    sel.tone   = 1'b1; // a0 picks addr/data
                        3'd2:    sel.bank   = 1'b1;
                        3'd4:    sel.latch0 = 1'b1;
                        3'd5:    sel.latch1 = 1'b1;
                        default: ;                  // adpcm and spare slots
                    endcase
                end
                default: ; // C and E pages are empty
            endcase
        end
    end

    // rom_cs decoded on its own, cross checked against sel.rom below
    assign rom_cs = cpu.mreq & (~cpu.addr[15] | (cpu.addr[15:14] == 2'b10));

    // hold the bus while the rom answer is pending
    assign wait_n = ~(rom_cs & ~rom_ok);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (sel.bank && cpu.wr) begin
            bank <= cpu.wdata[0];
        end
    end

    // read priority tone, latch0, latch1, (ram), rom, idle
    // ram is left out here, its q is already one cycle late
    always_comb begin
        if (sel.tone)
            rd_mux = tone_q;
        else if (sel.latch0)
            rd_mux = snd_latch0;
        else if (sel.latch1)
            rd_mux = snd_latch1;
        else if (sel.rom)
            rd_mux = rom_data;
        else
            rd_mux = 8'hff; // nothing there, ram also lands here
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_r <= 8'hff;
            rd_ram  <= 1'b0;
        end else begin
            rdata_r <= rd_mux;
            rd_ram  <= sel.ram & ~cpu.wr;
        end
    end

    // both halves come straight out of registers
    assign rdata = rd_ram ? ram_q : rdata_r;

    a_sel_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(sel)
    ) else $error("sel not one-hot: %h", sel);

    a_rom_cs: assert property (
        @(posedge clk) disable iff (rst) rom_cs == sel.rom
    ) else $error("rom_cs %h differs from sel.rom %h", rom_cs, sel.rom);

endmodule

/* hw/snd_ram.sv */
/* single port work ram, synchronous read, no reset
   a read during a write returns the old contents */
`timescale 1ns/100ps
`include "snd_settings.svh"

module snd_ram import snd_bus_pkg::*; #(
    parameter int aw = `SND_RAM_AW
) (
    input  logic          clk,
    input  logic [aw-1:0] addr,
    input  cpu_data_t     wdata,
    input  logic          we,
    output cpu_data_t     q
);

    cpu_data_t mem [2**aw]; // contents undefined at power up

    always_ff @(posedge clk) begin
        q <= mem[addr]; // read first
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // an X address would corrupt an unknown location
    a_wr_addr_known: assert property (
        @(posedge clk) we |-> !$isunknown(addr)
    ) else $error("ram write with unknown addr %h", addr);

endmodule

/* hw/snd_tone.sv */
/* one channel square wave tone chip with fm style register pair
   a0 low writes the register index, a0 high writes the register
   reads always return status, timer flag in bit 0 */
`timescale 1ns/100ps
`include "snd_settings.svh"

module snd_tone import snd_bus_pkg::*, snd_audio_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen_fm,   // phase step enable
    input  logic      cen_fm2,  // sample strobe
    input  logic      cs,
    input  logic      we,
    input  logic      a0,
    input  cpu_data_t wdata,
    output cpu_data_t rdata,
    output sample_t   left,
    output sample_t   right,
    output logic      sample,
    output logic      irq
);

    // register indices behind the data port
    localparam cpu_data_t REG_FREQ_LO = 8'd0;
    localparam cpu_data_t REG_FREQ_HI = 8'd1;
    localparam cpu_data_t REG_VOL_L   = 8'd2;
    localparam cpu_data_t REG_VOL_R   = 8'd3;
    localparam cpu_data_t REG_TIMER   = 8'd4;
    localparam cpu_data_t REG_CTL     = 8'd5;

    tone_regs_t regs;
    cpu_data_t  reg_sel;    // index latched by an a0=0 write
    phase_t     phase;
    logic [7:0] timer_cnt;  // samples since last tick
    logic       flag;       // timer flag, sticky
    logic       wr_en;
    logic       wr_data;    // write through the data port
    logic       clr_flag;
    sample_t    mag_l;
    sample_t    mag_r;

    assign wr_en    = cs & we;
    assign wr_data  = wr_en & a0;
    assign clr_flag = wr_data && (reg_sel == REG_CTL) && wdata[1];

    // cpu register writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs    <= '0;
            reg_sel <= '0;
        end else if (wr_en) begin
            if (!a0) begin
                reg_sel <= wdata;
            end else begin
                case (reg_sel)
                    REG_FREQ_LO: regs.freq[7:0] <= wdata;
                    REG_FREQ_HI: regs.freq[`SND_PHASE_W-1:8] <= wdata[`SND_PHASE_W-9:0];
                    REG_VOL_L:   regs.vol_l <= wdata;
                    REG_VOL_R:   regs.vol_r <= wdata;
                    REG_TIMER:   regs.timer_period <= wdata;
                    REG_CTL:     regs.irq_en <= wdata[0]; // bit 1 is the clear strobe
                    default:     ;                        // unmapped index, ignored
                endcase
            end
        end
    end

    // timer, counts sample strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer_cnt <= '0;
            flag      <= 1'b0;
        end else begin
            if (clr_flag) flag <= 1'b0;
            if (wr_data && reg_sel == REG_TIMER) begin
                timer_cnt <= '0; // new period restarts the count
            end else if (cen_fm2 && regs.timer_period != 8'd0) begin
                if (timer_cnt == regs.timer_period - 8'd1) begin
                    timer_cnt <= '0;
                    flag      <= 1'b1; // set wins over a same cycle clear
                end else begin
                    timer_cnt <= timer_cnt + 8'd1;
                end
            end
        end
    end

    assign irq   = flag & regs.irq_en;
    assign rdata = {7'd0, flag};

    // output magnitude, zero extended volume then shifted
    assign mag_l = sample_t'(regs.vol_l) <<< `SND_VOL_SHIFT;
    assign mag_r = sample_t'(regs.vol_r) <<< `SND_VOL_SHIFT;

    // phase and sample path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase  <= '0;
            left   <= '0;
            right  <= '0;
            sample <= 1'b0;
        end else begin
            sample <= cen_fm2; // one cycle per strobe
            if (cen_fm) phase <= phase + regs.freq;
            if (cen_fm2) begin
                // msb low is the positive half of the square
                left  <= phase[`SND_PHASE_W-1] ? -mag_l : mag_l;
                right <= phase[`SND_PHASE_W-1] ? -mag_r : mag_r;
            end
        end
    end

    // strobe must come at most every other cycle
    a_sample_pulse: assert property (
        @(posedge clk) disable iff (rst) sample |=> !sample
    ) else $error("sample high two cycles in a row");

    // irq comes up only after a sample strobe or a data port write
    a_irq_rise: assert property (
        @(posedge clk) disable iff (rst) $rose(irq) |-> $past(cen_fm2) || $past(wr_data)
    ) else $error("irq rose without a sample strobe or register write");

endmodule

/* hw/snd_top.sv */
/* sound board glue around an external cpu bus
   no adpcm chip, no io or interrupt acknowledge cycles */
`timescale 1ns/100ps
`include "snd_settings.svh"

module snd_top import snd_bus_pkg::*, snd_audio_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen_fm,
    input  logic      cen_fm2,
    input  cpu_bus_t  cpu,
    input  cpu_data_t snd_latch0,   // from main cpu
    input  cpu_data_t snd_latch1,
    input  cpu_data_t rom_data,
    input  logic      rom_ok,
    output cpu_data_t rdata,
    output logic      wait_n,
    output logic      irq,
    output cpu_addr_t rom_addr,
    output logic      rom_cs,
    output sample_t   left,
    output sample_t   right,
    output logic      sample
);

    dev_sel_t  sel;
    cpu_data_t ram_q;
    cpu_data_t tone_q;   // tone status byte

    snd_map i_map (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cpu        ( cpu        ),
        .snd_latch0 ( snd_latch0 ),
        .snd_latch1 ( snd_latch1 ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .ram_q      ( ram_q      ),
        .tone_q     ( tone_q     ),
        .sel        ( sel        ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .rdata      ( rdata      ),
        .wait_n     ( wait_n     )
    );

    // low address bits only, so the ram repeats across the D page
    snd_ram #(.aw(`SND_RAM_AW)) i_ram (
        .clk   ( clk                          ),
        .addr  ( cpu.addr[`SND_RAM_AW-1:0]    ),
        .wdata ( cpu.wdata                    ),
        .we    ( sel.ram & cpu.wr             ),
        .q     ( ram_q                        )
    );

    snd_tone i_tone (
        .clk     ( clk         ),
        .rst     ( rst         ),
        .cen_fm  ( cen_fm      ),
        .cen_fm2 ( cen_fm2     ),
        .cs      ( sel.tone    ),
        .we      ( cpu.wr      ), // qualified by cs inside
        .a0      ( cpu.addr[0] ),
        .wdata   ( cpu.wdata   ),
        .rdata   ( tone_q      ),
        .left    ( left        ),
        .right   ( right       ),
        .sample  ( sample      ),
        .irq     ( irq         )
    );

endmodule

/* test/snd_tb.sv */
/* testbench for snd_top, plays the sound cpu on the plain bus
   every check is a concurrent assertion, the first failure ends the run
   rom model stalls 0..3 extra cycles, delay drawn from an lfsr */
`timescale 1ns/100ps
`include "snd_settings.svh"

module snd_tb import snd_bus_pkg::*, snd_audio_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000; // sequence needs ~1500
    localparam logic [31:0] LFSR_SEED = 32'd78349;

    logic      clk = 1'b0;
    logic      rst;
    logic      cen_fm = 1'b0;
    logic      cen_fm2 = 1'b0;
    cpu_bus_t  cpu;
    cpu_data_t snd_latch0;
    cpu_data_t snd_latch1;
    cpu_data_t rom_data = 8'h00;
    logic      rom_ok = 1'b0;
    cpu_data_t rdata;
    logic      wait_n;
    logic      irq;
    cpu_addr_t rom_addr;
    logic      rom_cs;
    sample_t   left;
    sample_t   right;
    logic      sample;

    int          cyc = 0;
    logic [31:0] rom_lfsr = LFSR_SEED;   // rom delay stream
    logic [31:0] data_lfsr = LFSR_SEED;  // ram address and data stream
    logic        rom_busy = 1'b0;
    logic [1:0]  rom_left = 2'd0;        // wait cycles still to go
    logic        rd_chk = 1'b0;          // rdata checked at the next edge
    cpu_data_t   rd_exp = 8'h00;
    cpu_data_t   ram_ref [2**`SND_RAM_AW];

    // reference model of the chip registers, fed from the bus
    logic       bank_wr;
    logic       tone_wr;
    logic       exp_rom_cs;
    logic       bank_exp;
    cpu_data_t  tone_idx;
    phase_t     freq_ref;
    phase_t     ref_phase;
    vol_t       vol_l_ref;
    vol_t       vol_r_ref;
    logic [7:0] period_ref;
    logic [7:0] tick_cnt;
    logic       irq_en_ref;
    logic       flag_ref;
    logic       exp_sample;
    sample_t    exp_left;
    sample_t    exp_right;

    snd_top i_dut (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen_fm     ( cen_fm     ),
        .cen_fm2    ( cen_fm2    ),
        .cpu        ( cpu        ),
        .snd_latch0 ( snd_latch0 ),
        .snd_latch1 ( snd_latch1 ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .rdata      ( rdata      ),
        .wait_n     ( wait_n     ),
        .irq        ( irq        ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .left       ( left       ),
        .right      ( right      ),
        .sample     ( sample     )
    );

    always #4 clk = ~clk; // 8 ns period

    function automatic logic [31:0] lfsr_step(input logic [31:0] st);
        // galois form, x^32 + x^22 + x^2 + x + 1
        return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
    endfunction

    task automatic lfsr_draw(input int n, inout logic [31:0] st, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st  = lfsr_step(st);
            val = {val[14:0], st[0]}; // one step per bit
        end
    endtask

    // rom contents, every address bit counts
    function automatic cpu_data_t rom_byte(input cpu_addr_t ra);
        return ra[7:0] ^ {ra[12:8], ra[15:13]} ^ 8'h6b;
    endfunction

    function automatic cpu_addr_t exp_rom_addr(input cpu_addr_t a, input logic bk);
        if (!a[15])
            return {1'b0, a[14:0]};   // fixed window
        return {1'b1, bk, a[13:0]};   // banked window
    endfunction

    function automatic sample_t out_level(input vol_t v, input logic neg);
        sample_t mag;
        mag = sample_t'(int'(v) << `SND_VOL_SHIFT);
        return neg ? -mag : mag;      // msb set gives the negative half
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // all bus tasks start and end right after a rising edge
    task automatic bus_write(input cpu_addr_t a, input cpu_data_t d);
        cpu <= '{addr: a, wdata: d, mreq: 1'b1, wr: 1'b1};
        @(posedge clk); // write lands here
        cpu <= '0;
    endtask

    task automatic bus_read(input cpu_addr_t a, input cpu_data_t exp);
        cpu <= '{addr: a, wdata: 8'h00, mreq: 1'b1, wr: 1'b0};
        @(negedge clk);
        while (!wait_n) @(negedge clk); // held while rom is pending
        @(posedge clk);                 // request sampled
        cpu    <= '0;
        rd_exp <= exp;
        rd_chk <= 1'b1;
        @(posedge clk);                 // rdata checked here
        rd_chk <= 1'b0;
    endtask

    // bk is the bank the sequence last wrote
    task automatic rom_read(input cpu_addr_t a, input logic bk);
        bus_read(a, rom_byte(exp_rom_addr(a, bk)));
    endtask

    task automatic tone_reg(input cpu_data_t idx, input cpu_data_t d);
        bus_write(16'hf000, idx); // a0 low, index
        bus_write(16'hf001, d);   // a0 high, data
    endtask

    task automatic wait_samples(input int n);
        repeat (n) begin
            @(negedge clk);
            while (!sample) @(negedge clk);
        end
        @(posedge clk);
    endtask

    // rom model, answers from rom_addr after a random stall
    always @(posedge clk) begin
        logic [15:0] d;
        if (rst || !rom_cs) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (!rom_busy) begin
            lfsr_draw(2, rom_lfsr, d);
            rom_busy <= 1'b1;
            rom_left <= d[1:0];
            rom_ok   <= (d[1:0] == 2'd0);
            rom_data <= (d[1:0] == 2'd0) ? rom_byte(rom_addr) : ~rom_byte(rom_addr);
        end else if (!rom_ok) begin
            if (rom_left == 2'd1) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_byte(rom_addr);
            end
            rom_left <= rom_left - 2'd1;
        end
    end

    always @(posedge clk) begin
        cyc     <= cyc + 1;
        cen_fm  <= cyc[0];            // every second cycle
        cen_fm2 <= (cyc[3:0] == 4'hf); // every sixteenth
    end

    always @(posedge clk) begin
        if (cyc >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout, sequence not done after %0d cycles", cyc));
    end

    assign bank_wr = cpu.mreq && cpu.wr && cpu.addr[15:12] == 4'hf && cpu.addr[3:1] == 3'd2;
    assign tone_wr = cpu.mreq && cpu.wr && cpu.addr[15:12] == 4'hf && cpu.addr[3:1] == 3'd0;
    assign exp_rom_cs = cpu.mreq && cpu.addr <= 16'hbfff; // fixed and banked windows

    always @(posedge clk) begin
        if (rst) begin
            bank_exp   <= 1'b0;
            tone_idx   <= '0;
            freq_ref   <= '0;
            ref_phase  <= '0;
            vol_l_ref  <= '0;
            vol_r_ref  <= '0;
            period_ref <= '0;
            tick_cnt   <= '0;
            irq_en_ref <= 1'b0;
            flag_ref   <= 1'b0;
            exp_sample <= 1'b0;
            exp_left   <= '0;
            exp_right  <= '0;
        end else begin
            exp_sample <= cen_fm2;
            if (cen_fm) ref_phase <= ref_phase + freq_ref;
            if (cen_fm2) begin
                exp_left  <= out_level(vol_l_ref, ref_phase[`SND_PHASE_W-1]);
                exp_right <= out_level(vol_r_ref, ref_phase[`SND_PHASE_W-1]);
            end
            if (bank_wr) bank_exp <= cpu.wdata[0];
            if (tone_wr && !cpu.addr[0]) tone_idx <= cpu.wdata;
            if (tone_wr && cpu.addr[0]) begin
                case (tone_idx)
                    8'd0: freq_ref[7:0] <= cpu.wdata;
                    8'd1: freq_ref[`SND_PHASE_W-1:8] <= cpu.wdata[`SND_PHASE_W-9:0];
                    8'd2: vol_l_ref <= cpu.wdata;
                    8'd3: vol_r_ref <= cpu.wdata;
                    8'd4: period_ref <= cpu.wdata;
                    8'd5: irq_en_ref <= cpu.wdata[0];
                    default: ;
                endcase
            end
            if (tone_wr && cpu.addr[0] && tone_idx == 8'd5 && cpu.wdata[1])
                flag_ref <= 1'b0;
            if (tone_wr && cpu.addr[0] && tone_idx == 8'd4) begin
                tick_cnt <= '0;                  // period write restarts
            end else if (cen_fm2 && period_ref != 8'd0) begin
                if (tick_cnt + 8'd1 == period_ref) begin
                    tick_cnt <= '0;
                    flag_ref <= 1'b1;            // nth sample pulse
                end else begin
                    tick_cnt <= tick_cnt + 8'd1;
                end
            end
        end
    end

    a_rdata: assert property (@(posedge clk) disable iff (rst) rd_chk |-> rdata == rd_exp)
        else stop_on_error($sformatf("mismatch rdata got %h expected %h",
                                     $sampled(rdata), $sampled(rd_exp)));

    a_rom_cs: assert property (@(posedge clk) disable iff (rst) rom_cs == exp_rom_cs)
        else stop_on_error($sformatf("mismatch rom_cs got %h expected %h",
                                     $sampled(rom_cs), $sampled(exp_rom_cs)));

    // low only while a rom access waits for rom_ok
    a_wait_n: assert property (@(posedge clk) disable iff (rst)
        wait_n == (!exp_rom_cs || rom_ok))
        else stop_on_error($sformatf("mismatch wait_n got %h expected %h",
                                     $sampled(wait_n),
                                     !$sampled(exp_rom_cs) || $sampled(rom_ok)));

    a_rom_addr: assert property (@(posedge clk) disable iff (rst)
        exp_rom_cs |-> rom_addr == exp_rom_addr(cpu.addr, bank_exp))
        else stop_on_error($sformatf("mismatch rom_addr got %h expected %h", $sampled(rom_addr),
                                     exp_rom_addr($sampled(cpu.addr), $sampled(bank_exp))));

    a_left: assert property (@(posedge clk) disable iff (rst) left == exp_left)
        else stop_on_error($sformatf("mismatch left got %h expected %h",
                                     $sampled(left), $sampled(exp_left)));

    a_right: assert property (@(posedge clk) disable iff (rst) right == exp_right)
        else stop_on_error($sformatf("mismatch right got %h expected %h",
                                     $sampled(right), $sampled(exp_right)));

    a_sample: assert property (@(posedge clk) disable iff (rst) sample == exp_sample)
        else stop_on_error($sformatf("mismatch sample got %h expected %h",
                                     $sampled(sample), $sampled(exp_sample)));

    a_sample_len: assert property (@(posedge clk) disable iff (rst) sample |=> !sample)
        else stop_on_error("sample pulse lasted longer than one cycle");

    a_irq: assert property (@(posedge clk) disable iff (rst) irq == (flag_ref && irq_en_ref))
        else stop_on_error($sformatf("mismatch irq got %h expected %h",
                                     $sampled(irq), $sampled(flag_ref && irq_en_ref)));

    initial begin
        logic [15:0] rv;
        logic [15:0] dv;
        logic [`SND_RAM_AW-1:0] ra[8];
        rst        <= 1'b1;
        cpu        <= '0;
        snd_latch0 <= 8'h3c;
        snd_latch1 <= 8'hc5;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // fixed window, corners then random
        rom_read(16'h0000, 1'b0);
        rom_read(16'h7fff, 1'b0);
        for (int i = 0; i < 6; i++) begin
            lfsr_draw(15, data_lfsr, rv);
            rom_read({1'b0, rv[14:0]}, 1'b0);
        end

        // banked window, bank low out of reset
        rom_read(16'h8123, 1'b0);
        bus_write(16'hf004, 8'h00);
        rom_read(16'ha5a5, 1'b0);
        bus_write(16'hf004, 8'h01);
        rom_read(16'h8001, 1'b1);
        rom_read(16'hbfff, 1'b1);
        bus_write(16'hf005, 8'hfe); // only bit 0 counts
        rom_read(16'h9abc, 1'b0);

        // work ram, random address and data
        for (int i = 0; i < 8; i++) begin
            lfsr_draw(`SND_RAM_AW, data_lfsr, rv);
            lfsr_draw(8, data_lfsr, dv);
            ra[i] = rv[`SND_RAM_AW-1:0];
            ram_ref[ra[i]] = dv[7:0];
            bus_write(16'hd000 | 16'(ra[i]), dv[7:0]);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(16'hd000 | 16'(ra[i]), ram_ref[ra[i]]);
            bus_read(16'hd800 | 16'(ra[i]), ram_ref[ra[i]]); // upper mirror
        end

        // latches and unmapped slots
        bus_read(16'hf008, 8'h3c);
        bus_read(16'hf00b, 8'hc5);
        snd_latch0 <= 8'h96;
        snd_latch1 <= 8'h21;
        bus_read(16'hf009, 8'h96);
        bus_read(16'hf00a, 8'h21);
        bus_read(16'hf002, 8'hff); // adpcm
        bus_read(16'hf006, 8'hff);
        bus_read(16'he000, 8'hff);
        bus_read(16'hc000, 8'hff);
        bus_read(16'hf00e, 8'hff);

        // tone output, sign flips every few samples
        tone_reg(8'd0, 8'h35);
        tone_reg(8'd1, 8'h0a);
        tone_reg(8'd2, 8'h80);
        tone_reg(8'd3, 8'h21);
        wait_samples(12);
        tone_reg(8'd2, 8'hff);    // full scale left
        wait_samples(12);

        // timer irq after the third sample pulse
        tone_reg(8'd4, 8'd3);
        tone_reg(8'd5, 8'h01);
        @(negedge clk);
        while (!irq) @(negedge clk);
        @(posedge clk);
        bus_read(16'hf000, 8'h01);
        bus_write(16'hf001, 8'h03); // clear, irq_en kept
        bus_read(16'hf001, 8'h00);
        tone_reg(8'd4, 8'd0);       // timer stopped
        repeat (40) @(posedge clk);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+hw
hw/snd_bus_pkg.sv
hw/snd_audio_pkg.sv
hw/snd_map.sv
hw/snd_ram.sv
hw/snd_tone.sv
hw/snd_top.sv
test/snd_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the sound board testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sim.f --top-module snd_tb \
    -Mdir obj_dir -o snd_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/snd_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0
